// File: hdl/vliw_settings.svh
`ifndef VLIW_SETTINGS_SVH
`define VLIW_SETTINGS_SVH

// Datapath and register file
`define VLIW_XLEN     32
`define VLIW_NREG     32
`define VLIW_RADDR    5
`define VLIW_LINK_REG 31

// Top bit of each field in one 32-bit instruction
`define VLIW_OP_HI    31
`define VLIW_RT_HI    25
`define VLIW_RA_HI    20
// Register b and the 16-bit immediate share this top bit
`define VLIW_RB_HI    15

`endif

// File: hdl/vliw_pkg.sv
`default_nettype none

package vliw_pkg;

    // Kept instruction set where Nop must stay zero
    typedef enum logic [5:0] {
        Nop   = 6'd0,
        Addi  = 6'd1,
        Subi  = 6'd2,
        Add   = 6'd3,
        Sub   = 6'd4,
        Srawi = 6'd5,
        Slawi = 6'd6,
        Xor   = 6'd7,
        And   = 6'd8,
        Li    = 6'd9,
        Liw   = 6'd10,
        Cmpd  = 6'd11,
        Cmpdi = 6'd12,
        // Flow control for the upper slot only
        Jump  = 6'd13,
        Bl    = 6'd14,
        Blr   = 6'd15,
        Blrr  = 6'd16,
        Beq   = 6'd17,
        Bne   = 6'd18,
        Blt   = 6'd19,
        Ble   = 6'd20,
        Bgt   = 6'd21,
        Bge   = 6'd22,
        End   = 6'd23
    } opcode_t;

    // Operation handed from decode to the slot ALUs
    typedef enum logic [3:0] {
        ENop    = 4'd0,
        EAdd    = 4'd1,
        ESub    = 4'd2,
        ERshift = 4'd3,
        ELshift = 4'd4,
        EXor    = 4'd5,
        EAnd    = 4'd6,
        EPass   = 4'd7     // result is source b
    } exec_t;

endpackage

`default_nettype wire

// File: hdl/gpr_file.sv
`timescale 1ns/1ps
`default_nettype none
`include "vliw_settings.svh"

module gpr_file (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic [`VLIW_RADDR-1:0] ra0,
    input  logic [`VLIW_RADDR-1:0] ra1,
    input  logic [`VLIW_RADDR-1:0] ra2,
    input  logic [`VLIW_RADDR-1:0] ra3,
    input  logic [`VLIW_RADDR-1:0] ra4,
    output logic [`VLIW_XLEN-1:0]  rd0,
    output logic [`VLIW_XLEN-1:0]  rd1,
    output logic [`VLIW_XLEN-1:0]  rd2,
    output logic [`VLIW_XLEN-1:0]  rd3,
    output logic [`VLIW_XLEN-1:0]  rd4,
    input  logic                   we0,
    input  logic [`VLIW_RADDR-1:0] wa0,
    input  logic [`VLIW_XLEN-1:0]  wd0,
    input  logic                   we1,
    input  logic [`VLIW_RADDR-1:0] wa1,
    input  logic [`VLIW_XLEN-1:0]  wd1
);

    logic [`VLIW_XLEN-1:0] regs [`VLIW_NREG];

    // A write is visible to the combinational reads after its edge
    assign rd0 = regs[ra0];
    assign rd1 = regs[ra1];
    assign rd2 = regs[ra2];
    assign rd3 = regs[ra3];
    assign rd4 = regs[ra4];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < `VLIW_NREG; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (we0) regs[wa0] <= wd0;
            if (we1) regs[wa1] <= wd1;
        end
    end

    // Result stage must have resolved same-register conflicts
    assert property (@(posedge clk) disable iff (!rstn) !(we0 && we1 && (wa0 == wa1)))
        else $error("gpr_file: both ports write register %0d", wa0);

endmodule

`default_nettype wire

// File: hdl/bundle_decode.sv
`timescale 1ns/1ps
`default_nettype none
`include "vliw_settings.svh"

module bundle_decode (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   stall,
    input  logic [31:0]            pc,
    input  logic [63:0]            bundle,
    input  logic [`VLIW_XLEN-1:0]  u_rd_a,
    input  logic [`VLIW_XLEN-1:0]  u_rd_b,
    input  logic [`VLIW_XLEN-1:0]  u_rd_s,
    input  logic [`VLIW_XLEN-1:0]  l_rd_a,
    input  logic [`VLIW_XLEN-1:0]  l_rd_b,
    input  logic [`VLIW_XLEN-1:0]  link_rd,
    output logic [`VLIW_RADDR-1:0] u_ra,
    output logic [`VLIW_RADDR-1:0] u_rb,
    output logic [`VLIW_RADDR-1:0] u_rs,
    output logic [`VLIW_RADDR-1:0] l_ra,
    output logic [`VLIW_RADDR-1:0] l_rb,
    output logic                   branch_flag,
    output logic [31:0]            branch_pc,
    output logic                   halted,
    output logic [`VLIW_XLEN-1:0]  u_srca,
    output logic [`VLIW_XLEN-1:0]  u_srcb,
    output logic [`VLIW_XLEN-1:0]  l_srca,
    output logic [`VLIW_XLEN-1:0]  l_srcb,
    output vliw_pkg::exec_t        u_e_type,
    output vliw_pkg::exec_t        l_e_type,
    output logic [`VLIW_RADDR-1:0] u_rt,
    output logic [`VLIW_RADDR-1:0] l_rt,
    output logic                   u_rt_flag,
    output logic                   l_rt_flag
);

    localparam logic [`VLIW_RADDR-1:0] link_reg = `VLIW_LINK_REG;

    logic [31:0]           u_word;
    logic [31:0]           l_word;
    vliw_pkg::opcode_t     u_op;
    vliw_pkg::opcode_t     l_raw;
    vliw_pkg::opcode_t     l_op;
    logic                  lower_kill;
    logic [`VLIW_XLEN-1:0] u_si;
    logic [`VLIW_XLEN-1:0] l_si;
    logic                  accept;
    logic                  taken;
    logic                  cmp_hit;
    logic [`VLIW_XLEN-1:0] cmp_a;
    logic [`VLIW_XLEN-1:0] cmp_b;
    logic                  eq;
    logic                  less;

    function automatic logic is_flow(input vliw_pkg::opcode_t op);
        is_flow = op inside {vliw_pkg::Jump, vliw_pkg::Bl, vliw_pkg::Blr, vliw_pkg::Blrr,
                             vliw_pkg::Beq, vliw_pkg::Bne, vliw_pkg::Blt, vliw_pkg::Ble,
                             vliw_pkg::Bgt, vliw_pkg::Bge};
    endfunction

    // Anything that is not ENop writes its target
    function automatic vliw_pkg::exec_t exec_of(input vliw_pkg::opcode_t op);
        case (op)
            vliw_pkg::Addi, vliw_pkg::Add:   exec_of = vliw_pkg::EAdd;
            vliw_pkg::Subi, vliw_pkg::Sub:   exec_of = vliw_pkg::ESub;
            vliw_pkg::Srawi:                 exec_of = vliw_pkg::ERshift;
            vliw_pkg::Slawi:                 exec_of = vliw_pkg::ELshift;
            vliw_pkg::Xor:                   exec_of = vliw_pkg::EXor;
            vliw_pkg::And:                   exec_of = vliw_pkg::EAnd;
            vliw_pkg::Li, vliw_pkg::Liw,
            vliw_pkg::Bl, vliw_pkg::Blrr:    exec_of = vliw_pkg::EPass;
            default:                         exec_of = vliw_pkg::ENop;
        endcase
    endfunction

    function automatic logic [`VLIW_XLEN-1:0] src_b(input vliw_pkg::opcode_t op,
                                                    input logic [`VLIW_XLEN-1:0] rd_b,
                                                    input logic [`VLIW_XLEN-1:0] si,
                                                    input logic [`VLIW_XLEN-1:0] wide,
                                                    input logic [`VLIW_XLEN-1:0] ret);
        case (op)
            vliw_pkg::Add, vliw_pkg::Sub,
            vliw_pkg::Xor, vliw_pkg::And:  src_b = rd_b;
            vliw_pkg::Liw:                 src_b = wide;
            vliw_pkg::Bl, vliw_pkg::Blrr:  src_b = ret;
            default:                       src_b = si;
        endcase
    endfunction

    assign u_word = bundle[63:32];
    assign l_word = bundle[31:0];
    assign u_op   = vliw_pkg::opcode_t'(u_word[`VLIW_OP_HI:`VLIW_RT_HI+1]);
    assign l_raw  = vliw_pkg::opcode_t'(l_word[`VLIW_OP_HI:`VLIW_RT_HI+1]);

    // Liw or a branch in the upper slot owns the whole bundle
    assign lower_kill = is_flow(u_op) || (u_op == vliw_pkg::Liw);
    assign l_op = (lower_kill || is_flow(l_raw) || (l_raw == vliw_pkg::Liw)) ?
                  vliw_pkg::Nop : l_raw;

    assign u_si = {{(`VLIW_XLEN-`VLIW_RB_HI-1){u_word[`VLIW_RB_HI]}}, u_word[`VLIW_RB_HI:0]};
    assign l_si = {{(`VLIW_XLEN-`VLIW_RB_HI-1){l_word[`VLIW_RB_HI]}}, l_word[`VLIW_RB_HI:0]};

    assign u_ra = u_word[`VLIW_RA_HI -: `VLIW_RADDR];
    assign u_rb = u_word[`VLIW_RB_HI -: `VLIW_RADDR];
    assign u_rs = (u_op == vliw_pkg::Blr) ? link_reg : u_word[`VLIW_RT_HI -: `VLIW_RADDR];
    assign l_ra = l_word[`VLIW_RA_HI -: `VLIW_RADDR];
    assign l_rb = l_word[`VLIW_RB_HI -: `VLIW_RADDR];

    assign accept = !stall && !branch_flag && !halted;

    // Upper compare takes precedence
    always_comb begin
        cmp_hit = 1'b1;
        if (u_op == vliw_pkg::Cmpd || u_op == vliw_pkg::Cmpdi) begin
            cmp_a = u_rd_a;
            cmp_b = (u_op == vliw_pkg::Cmpd) ? u_rd_b : u_si;
        end else begin
            cmp_a   = l_rd_a;
            cmp_b   = (l_op == vliw_pkg::Cmpd) ? l_rd_b : l_si;
            cmp_hit = (l_op == vliw_pkg::Cmpd) || (l_op == vliw_pkg::Cmpdi);
        end
    end

    // Flags as held before this bundle
    always_comb begin
        case (u_op)
            vliw_pkg::Jump, vliw_pkg::Bl,
            vliw_pkg::Blr, vliw_pkg::Blrr:  taken = 1'b1;
            vliw_pkg::Beq:                  taken = eq;
            vliw_pkg::Bne:                  taken = !eq;
            vliw_pkg::Blt:                  taken = less;
            vliw_pkg::Ble:                  taken = less || eq;
            vliw_pkg::Bgt:                  taken = !(less || eq);
            vliw_pkg::Bge:                  taken = !less;
            default:                        taken = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            branch_flag <= 1'b0;
            halted      <= 1'b0;
            u_rt_flag   <= 1'b0;
            l_rt_flag   <= 1'b0;
            u_e_type    <= vliw_pkg::ENop;
            l_e_type    <= vliw_pkg::ENop;
            eq          <= 1'b0;
            less        <= 1'b0;
        end else begin
            branch_flag <= accept && taken;
            if (accept) begin
                u_e_type  <= exec_of(u_op);
                l_e_type  <= exec_of(l_op);
                u_rt_flag <= exec_of(u_op) != vliw_pkg::ENop;
                l_rt_flag <= exec_of(l_op) != vliw_pkg::ENop;
                if (u_op == vliw_pkg::End || l_op == vliw_pkg::End) begin
                    halted <= 1'b1;
                end
                if (cmp_hit) begin
                    eq   <= cmp_a == cmp_b;
                    less <= $signed(cmp_a) < $signed(cmp_b);
                end
            end else begin
                // Issue Nop when stalled, discarded or halted
                u_e_type  <= vliw_pkg::ENop;
                l_e_type  <= vliw_pkg::ENop;
                u_rt_flag <= 1'b0;
                l_rt_flag <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            u_srca <= u_rd_a;
            l_srca <= l_rd_a;
            u_srcb <= src_b(u_op, u_rd_b, u_si, l_word, pc + 32'd1);
            l_srcb <= src_b(l_op, l_rd_b, l_si, l_word, pc + 32'd1);
            u_rt   <= (u_op == vliw_pkg::Bl || u_op == vliw_pkg::Blrr) ?
                      link_reg : u_word[`VLIW_RT_HI -: `VLIW_RADDR];
            l_rt   <= l_word[`VLIW_RT_HI -: `VLIW_RADDR];
            case (u_op)
                vliw_pkg::Blr:  branch_pc <= link_rd;
                vliw_pkg::Blrr: branch_pc <= u_rd_s;
                default:        branch_pc <= 32'(u_word[`VLIW_RT_HI:0]);
            endcase
        end
    end

    // A taken branch writes nothing but the link register
    assert property (@(posedge clk) disable iff (!rstn)
                     branch_flag |-> !l_rt_flag && (!u_rt_flag || (u_rt == link_reg)))
        else $error("bundle_decode: taken branch writes other than the link register");

endmodule

`default_nettype wire

// File: hdl/slot_alu.sv
`timescale 1ns/1ps
`default_nettype none
`include "vliw_settings.svh"

module slot_alu (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic [`VLIW_XLEN-1:0]  srca,
    input  logic [`VLIW_XLEN-1:0]  srcb,
    input  vliw_pkg::exec_t        e_type,
    input  logic [`VLIW_RADDR-1:0] rt_in,
    input  logic                   rt_flag_in,
    output logic [`VLIW_XLEN-1:0]  res,
    output logic [`VLIW_RADDR-1:0] rt,
    output logic                   rt_flag
);

    logic [`VLIW_XLEN-1:0] alu;

    always_comb begin
        case (e_type)
            vliw_pkg::EAdd:    alu = srca + srcb;
            vliw_pkg::ESub:    alu = srca - srcb;
            // Shift amount from the low five bits only
            vliw_pkg::ERshift: alu = $signed(srca) >>> srcb[4:0];
            vliw_pkg::ELshift: alu = srca << srcb[4:0];
            vliw_pkg::EXor:    alu = srca ^ srcb;
            vliw_pkg::EAnd:    alu = srca & srcb;
            vliw_pkg::EPass:   alu = srcb;
            default:           alu = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            rt_flag <= 1'b0;
        end else begin
            rt_flag <= rt_flag_in;
        end
    end

    always_ff @(posedge clk) begin
        res <= alu;
        rt  <= rt_in;
    end

    // Decode never asks for a write without an operation
    assert property (@(posedge clk) disable iff (!rstn)
                     rt_flag_in |-> (e_type != vliw_pkg::ENop))
        else $error("slot_alu: write to r%0d with ENop", rt_in);

endmodule

`default_nettype wire

// File: hdl/slot_result.sv
`timescale 1ns/1ps
`default_nettype none
`include "vliw_settings.svh"

module slot_result (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic [`VLIW_XLEN-1:0]  u_res,
    input  logic [`VLIW_RADDR-1:0] u_rt,
    input  logic                   u_rt_flag,
    input  logic [`VLIW_XLEN-1:0]  l_res,
    input  logic [`VLIW_RADDR-1:0] l_rt,
    input  logic                   l_rt_flag,
    output logic                   u_wb_en,
    output logic [`VLIW_RADDR-1:0] u_wb_addr,
    output logic [`VLIW_XLEN-1:0]  u_wb_data,
    output logic                   l_wb_en,
    output logic [`VLIW_RADDR-1:0] l_wb_addr,
    output logic [`VLIW_XLEN-1:0]  l_wb_data
);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            u_wb_en <= 1'b0;
            l_wb_en <= 1'b0;
        end else begin
            u_wb_en <= u_rt_flag;
            // Upper wins when both slots share a target
            l_wb_en <= l_rt_flag && !(u_rt_flag && (u_rt == l_rt));
        end
    end

    always_ff @(posedge clk) begin
        u_wb_addr <= u_rt;
        u_wb_data <= u_res;
        l_wb_addr <= l_rt;
        l_wb_data <= l_res;
    end

    // Enabled write-backs carry known address and data
    assert property (@(posedge clk) disable iff (!rstn)
                     !(u_wb_en && $isunknown({u_wb_addr, u_wb_data})) &&
                     !(l_wb_en && $isunknown({l_wb_addr, l_wb_data})))
        else $error("slot_result: write-back with unknown address or data");

endmodule

`default_nettype wire

// File: hdl/vliw_core.sv
`timescale 1ns/1ps
`default_nettype none
`include "vliw_settings.svh"

module vliw_core (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   stall,
    input  logic [31:0]            pc,
    input  logic [63:0]            bundle,
    output logic                   branch_flag,
    output logic [31:0]            branch_pc,
    output logic                   halted,
    output logic                   u_wb_en,
    output logic [`VLIW_RADDR-1:0] u_wb_addr,
    output logic [`VLIW_XLEN-1:0]  u_wb_data,
    output logic                   l_wb_en,
    output logic [`VLIW_RADDR-1:0] l_wb_addr,
    output logic [`VLIW_XLEN-1:0]  l_wb_data
);

    logic [`VLIW_RADDR-1:0] u_ra, u_rb, u_rs, l_ra, l_rb;
    logic [`VLIW_XLEN-1:0]  u_rd_a, u_rd_b, s_rd, l_rd_a, l_rd_b;
    logic [`VLIW_XLEN-1:0]  u_srca, u_srcb, l_srca, l_srcb;
    vliw_pkg::exec_t        u_e_type, l_e_type;
    logic [`VLIW_RADDR-1:0] u_rt, l_rt, u_ex_rt, l_ex_rt;
    logic                   u_rt_flag, l_rt_flag, u_ex_flag, l_ex_flag;
    logic [`VLIW_XLEN-1:0]  u_res, l_res;

    // Port 4 serves both rt of Blrr and the link register of Blr
    bundle_decode i_decode (
        .clk, .rstn, .stall, .pc, .bundle,
        .u_rd_a, .u_rd_b, .u_rd_s(s_rd), .l_rd_a, .l_rd_b, .link_rd(s_rd),
        .u_ra, .u_rb, .u_rs, .l_ra, .l_rb,
        .branch_flag, .branch_pc, .halted,
        .u_srca, .u_srcb, .l_srca, .l_srcb, .u_e_type, .l_e_type,
        .u_rt, .l_rt, .u_rt_flag, .l_rt_flag
    );

    slot_alu u_alu (
        .clk, .rstn, .srca(u_srca), .srcb(u_srcb), .e_type(u_e_type),
        .rt_in(u_rt), .rt_flag_in(u_rt_flag),
        .res(u_res), .rt(u_ex_rt), .rt_flag(u_ex_flag)
    );

    slot_alu l_alu (
        .clk, .rstn, .srca(l_srca), .srcb(l_srcb), .e_type(l_e_type),
        .rt_in(l_rt), .rt_flag_in(l_rt_flag),
        .res(l_res), .rt(l_ex_rt), .rt_flag(l_ex_flag)
    );

    slot_result i_result (
        .clk, .rstn,
        .u_res, .u_rt(u_ex_rt), .u_rt_flag(u_ex_flag),
        .l_res, .l_rt(l_ex_rt), .l_rt_flag(l_ex_flag),
        .u_wb_en, .u_wb_addr, .u_wb_data, .l_wb_en, .l_wb_addr, .l_wb_data
    );

    gpr_file i_gpr (
        .clk, .rstn,
        .ra0(u_ra), .ra1(u_rb), .ra2(l_ra), .ra3(l_rb), .ra4(u_rs),
        .rd0(u_rd_a), .rd1(u_rd_b), .rd2(l_rd_a), .rd3(l_rd_b), .rd4(s_rd),
        .we0(u_wb_en), .wa0(u_wb_addr), .wd0(u_wb_data),
        .we1(l_wb_en), .wa1(l_wb_addr), .wd1(l_wb_data)
    );

endmodule

`default_nettype wire

// File: dv/vliw_core_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "vliw_settings.svh"

module vliw_core_tb;

    localparam int clk_period = 8;
    localparam int prog_len   = 40;
    localparam int seed_value = 84062;

    logic        clk;
    logic        rstn;
    logic        stall;
    logic [31:0] pc;
    logic [63:0] bundle;
    logic        branch_flag;
    logic [31:0] branch_pc;
    logic        halted;
    logic        u_wb_en;
    logic [4:0]  u_wb_addr;
    logic [31:0] u_wb_data;
    logic        l_wb_en;
    logic [4:0]  l_wb_addr;
    logic [31:0] l_wb_data;

    logic [63:0] prog [prog_len];
    logic [31:0] shadow [`VLIW_NREG];
    logic        m_eq;
    logic        m_less;
    logic        exp_branch;
    logic [31:0] exp_bpc;
    logic        exp_halted;
    // Index 2 lines up with the wb_* outputs
    logic        exp_u_en [3];
    logic [4:0]  exp_u_addr [3];
    logic [31:0] exp_u_data [3];
    logic        exp_l_en [3];
    logic [4:0]  exp_l_addr [3];
    logic [31:0] exp_l_data [3];
    integer      seed;
    int          errors;

    vliw_core i_vliw_core (
        .clk, .rstn, .stall, .pc, .bundle, .branch_flag, .branch_pc, .halted,
        .u_wb_en, .u_wb_addr, .u_wb_data, .l_wb_en, .l_wb_addr, .l_wb_data
    );

    function automatic logic [31:0] imm_form(input vliw_pkg::opcode_t op, input logic [4:0] rt,
                                             input logic [4:0] ra, input logic [15:0] imm);
        imm_form = {op, rt, ra, imm};
    endfunction

    function automatic logic [31:0] reg_form(input vliw_pkg::opcode_t op, input logic [4:0] rt,
                                             input logic [4:0] ra, input logic [4:0] rb);
        reg_form = {op, rt, ra, rb, 11'd0};
    endfunction

    function automatic logic [31:0] jump_form(input vliw_pkg::opcode_t op,
                                              input logic [25:0] target);
        jump_form = {op, target};
    endfunction

    function automatic logic [63:0] fetch_at(input logic [31:0] addr);
        fetch_at = (addr < prog_len) ? prog[addr] : 64'd0;
    endfunction

    function automatic logic owns_bundle(input logic [5:0] op);
        owns_bundle = op inside {vliw_pkg::Liw, vliw_pkg::Jump, vliw_pkg::Bl, vliw_pkg::Blr,
                                 vliw_pkg::Blrr, vliw_pkg::Beq, vliw_pkg::Bne, vliw_pkg::Blt,
                                 vliw_pkg::Ble, vliw_pkg::Bgt, vliw_pkg::Bge};
    endfunction

    function automatic logic is_cmp(input logic [5:0] op);
        is_cmp = (op == vliw_pkg::Cmpd) || (op == vliw_pkg::Cmpdi);
    endfunction

    // Bit 32 is the write flag
    function automatic logic [32:0] slot_value(input logic [31:0] w, input logic [31:0] a,
                                               input logic [31:0] b, input logic [31:0] wide,
                                               input logic [31:0] pc_in);
        logic        [31:0] imm;
        logic signed [31:0] sa;
        imm = {{16{w[15]}}, w[15:0]};
        sa  = a;
        case (w[31:26])
            vliw_pkg::Addi:  slot_value = {1'b1, a + imm};
            vliw_pkg::Subi:  slot_value = {1'b1, a - imm};
            vliw_pkg::Add:   slot_value = {1'b1, a + b};
            vliw_pkg::Sub:   slot_value = {1'b1, a - b};
            vliw_pkg::Srawi: slot_value = {1'b1, sa >>> imm[4:0]};
            vliw_pkg::Slawi: slot_value = {1'b1, a << imm[4:0]};
            vliw_pkg::Xor:   slot_value = {1'b1, a ^ b};
            vliw_pkg::And:   slot_value = {1'b1, a & b};
            vliw_pkg::Li:    slot_value = {1'b1, imm};
            vliw_pkg::Liw:   slot_value = {1'b1, wide};
            vliw_pkg::Bl, vliw_pkg::Blrr: slot_value = {1'b1, pc_in + 32'd1};
            default:         slot_value = 33'd0;
        endcase
    endfunction

    function automatic logic branch_taken(input logic [5:0] op, input logic eq, input logic less);
        case (op)
            vliw_pkg::Jump, vliw_pkg::Bl, vliw_pkg::Blr, vliw_pkg::Blrr: branch_taken = 1'b1;
            vliw_pkg::Beq: branch_taken = eq;
            vliw_pkg::Bne: branch_taken = !eq;
            vliw_pkg::Blt: branch_taken = less;
            vliw_pkg::Ble: branch_taken = less || eq;
            vliw_pkg::Bgt: branch_taken = !less && !eq;
            vliw_pkg::Bge: branch_taken = !less;
            default:       branch_taken = 1'b0;
        endcase
    endfunction

    task automatic update_flags(input logic [31:0] w);
        logic [31:0] a;
        logic [31:0] b;
        a = shadow[w[20:16]];
        b = (w[31:26] == vliw_pkg::Cmpd) ? shadow[w[15:11]] : {{16{w[15]}}, w[15:0]};
        m_eq   = (a == b);
        m_less = ($signed(a) < $signed(b));
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] want);
        errors++;
        $display("** Error: %s = %h, expected %h", name, got, want);
    endtask

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // Fetch and reference models advance on accepted bundles
    always @(posedge clk) begin : model
        logic [63:0] word;
        logic [31:0] uw;
        logic [31:0] lw;
        logic [32:0] uv;
        logic [32:0] lv;
        logic [4:0]  urt;
        logic        accept;
        logic        l_en;
        logic [31:0] next_pc;
        for (int s = 2; s > 0; s--) begin
            exp_u_en[s]   <= exp_u_en[s-1];
            exp_u_addr[s] <= exp_u_addr[s-1];
            exp_u_data[s] <= exp_u_data[s-1];
            exp_l_en[s]   <= exp_l_en[s-1];
            exp_l_addr[s] <= exp_l_addr[s-1];
            exp_l_data[s] <= exp_l_data[s-1];
        end
        if (!rstn) begin
            for (int i = 0; i < `VLIW_NREG; i++) begin
                shadow[i] = '0;
            end
            m_eq   = 1'b0;
            m_less = 1'b0;
            for (int s = 0; s < 3; s++) begin
                exp_u_en[s] <= 1'b0;
                exp_l_en[s] <= 1'b0;
            end
            exp_branch <= 1'b0;
            exp_bpc    <= '0;
            exp_halted <= 1'b0;
            pc         <= '0;
            bundle     <= fetch_at(32'd0);
            stall      <= 1'b0;
        end else begin
            accept      = !stall && !exp_branch && !exp_halted;
            exp_u_en[0] <= 1'b0;
            exp_l_en[0] <= 1'b0;
            exp_branch  <= 1'b0;
            if (accept) begin
                word = fetch_at(pc);
                uw   = word[63:32];
                lw   = owns_bundle(uw[31:26]) ? 32'd0 : word[31:0];
                uv   = slot_value(uw, shadow[uw[20:16]], shadow[uw[15:11]], word[31:0], pc);
                lv   = slot_value(lw, shadow[lw[20:16]], shadow[lw[15:11]], word[31:0], pc);
                urt  = (uw[31:26] == vliw_pkg::Bl || uw[31:26] == vliw_pkg::Blrr) ?
                       5'(`VLIW_LINK_REG) : uw[25:21];
                l_en = lv[32] && !(uv[32] && (urt == lw[25:21]));
                exp_u_en[0]   <= uv[32];
                exp_u_addr[0] <= urt;
                exp_u_data[0] <= uv[31:0];
                exp_l_en[0]   <= l_en;
                exp_l_addr[0] <= lw[25:21];
                exp_l_data[0] <= lv[31:0];
                exp_branch    <= branch_taken(uw[31:26], m_eq, m_less);
                case (uw[31:26])
                    vliw_pkg::Blr:  exp_bpc <= shadow[`VLIW_LINK_REG];
                    vliw_pkg::Blrr: exp_bpc <= shadow[uw[25:21]];
                    default:        exp_bpc <= {6'd0, uw[25:0]};
                endcase
                if (is_cmp(uw[31:26])) begin
                    update_flags(uw);
                end else if (is_cmp(lw[31:26])) begin
                    update_flags(lw);
                end
                if (uw[31:26] == vliw_pkg::End || lw[31:26] == vliw_pkg::End) begin
                    exp_halted <= 1'b1;
                end
                if (uv[32]) shadow[urt] = uv[31:0];
                if (l_en) shadow[lw[25:21]] = lv[31:0];
            end
            next_pc = exp_branch ? exp_bpc : (accept ? pc + 32'd1 : pc);
            pc     <= next_pc;
            bundle <= fetch_at(next_pc);
            stall  <= ($random(seed) & 3) == 0;
        end
    end

    assert property (@(posedge clk) disable iff (!rstn) branch_flag == exp_branch)
        else report_mismatch("branch_flag", $sampled(branch_flag), $sampled(exp_branch));
    assert property (@(posedge clk) disable iff (!rstn) exp_branch |-> branch_pc == exp_bpc)
        else report_mismatch("branch_pc", $sampled(branch_pc), $sampled(exp_bpc));
    assert property (@(posedge clk) disable iff (!rstn) halted == exp_halted)
        else report_mismatch("halted", $sampled(halted), $sampled(exp_halted));
    assert property (@(posedge clk) disable iff (!rstn) u_wb_en == exp_u_en[2])
        else report_mismatch("u_wb_en", $sampled(u_wb_en), $sampled(exp_u_en[2]));
    assert property (@(posedge clk) disable iff (!rstn)
                     exp_u_en[2] |-> u_wb_addr == exp_u_addr[2])
        else report_mismatch("u_wb_addr", $sampled(u_wb_addr), $sampled(exp_u_addr[2]));
    assert property (@(posedge clk) disable iff (!rstn)
                     exp_u_en[2] |-> u_wb_data == exp_u_data[2])
        else report_mismatch("u_wb_data", $sampled(u_wb_data), $sampled(exp_u_data[2]));
    assert property (@(posedge clk) disable iff (!rstn) l_wb_en == exp_l_en[2])
        else report_mismatch("l_wb_en", $sampled(l_wb_en), $sampled(exp_l_en[2]));
    assert property (@(posedge clk) disable iff (!rstn)
                     exp_l_en[2] |-> l_wb_addr == exp_l_addr[2])
        else report_mismatch("l_wb_addr", $sampled(l_wb_addr), $sampled(exp_l_addr[2]));
    assert property (@(posedge clk) disable iff (!rstn)
                     exp_l_en[2] |-> l_wb_data == exp_l_data[2])
        else report_mismatch("l_wb_data", $sampled(l_wb_data), $sampled(exp_l_data[2]));

    initial begin
        seed   = seed_value;
        errors = 0;
        rstn   = 1'b0;
        stall  = 1'b0;
        pc     = '0;
        bundle = '0;
        // Unused slots stay Nop
        for (int i = 0; i < prog_len; i++) begin
            prog[i] = 64'd0;
        end
        prog[0]  = {imm_form(vliw_pkg::Li, 1, 0, 100), imm_form(vliw_pkg::Li, 2, 0, -7)};
        prog[1]  = {imm_form(vliw_pkg::Liw, 3, 0, 0), imm_form(vliw_pkg::Addi, 5, 0, 16'h1234)};
        prog[2]  = {imm_form(vliw_pkg::Li, 4, 0, 3), imm_form(vliw_pkg::Li, 6, 0, 16'h0F0F)};
        prog[6]  = {reg_form(vliw_pkg::Add, 7, 1, 2), reg_form(vliw_pkg::Sub, 8, 1, 2)};
        prog[7]  = {imm_form(vliw_pkg::Addi, 9, 3, -5), imm_form(vliw_pkg::Subi, 10, 2, 20)};
        prog[8]  = {reg_form(vliw_pkg::Xor, 11, 3, 6), reg_form(vliw_pkg::And, 12, 3, 6)};
        prog[9]  = {imm_form(vliw_pkg::Srawi, 13, 2, 1), imm_form(vliw_pkg::Slawi, 14, 3, 4)};
        prog[10] = {imm_form(vliw_pkg::Cmpdi, 0, 1, 100), 32'd0};
        prog[11] = {jump_form(vliw_pkg::Beq, 13), imm_form(vliw_pkg::Addi, 17, 1, 1)};
        prog[12] = {imm_form(vliw_pkg::Li, 18, 0, 16'h0BAD), 32'd0};
        prog[13] = {jump_form(vliw_pkg::Bne, 0), 32'd0};
        // Upper compare wins over the lower one
        prog[14] = {reg_form(vliw_pkg::Cmpd, 0, 2, 1), imm_form(vliw_pkg::Cmpdi, 0, 1, -1)};
        prog[15] = {jump_form(vliw_pkg::Blt, 17), 32'd0};
        prog[16] = {imm_form(vliw_pkg::Li, 19, 0, 16'h0BAD), 32'd0};
        prog[17] = {jump_form(vliw_pkg::Bge, 0), 32'd0};
        prog[18] = {jump_form(vliw_pkg::Ble, 20), 32'd0};
        prog[19] = {imm_form(vliw_pkg::Li, 20, 0, 16'h0BAD), 32'd0};
        // Lower compare alone sets the flags
        prog[20] = {32'd0, imm_form(vliw_pkg::Cmpdi, 0, 1, -1)};
        prog[21] = {jump_form(vliw_pkg::Bgt, 23), 32'd0};
        prog[22] = {imm_form(vliw_pkg::Li, 21, 0, 16'h0BAD), 32'd0};
        // The return from this call lands on the bundle the call skipped
        prog[23] = {jump_form(vliw_pkg::Bl, 26), imm_form(vliw_pkg::Li, 22, 0, 16'h0BAD)};
        prog[24] = {imm_form(vliw_pkg::Li, 23, 0, 16'h0077), 32'd0};
        prog[25] = {jump_form(vliw_pkg::Jump, 30), 32'd0};
        prog[28] = {jump_form(vliw_pkg::Blr, 0), 32'd0};
        prog[29] = {imm_form(vliw_pkg::Li, 24, 0, 16'h0BAD), 32'd0};
        prog[30] = {imm_form(vliw_pkg::Li, 24, 0, 36), imm_form(vliw_pkg::Li, 25, 0, 7)};
        prog[34] = {imm_form(vliw_pkg::Blrr, 24, 0, 0), 32'd0};
        prog[35] = {imm_form(vliw_pkg::Li, 26, 0, 16'h0BAD), 32'd0};
        prog[36] = {reg_form(vliw_pkg::Add, 26, 25, 25), reg_form(vliw_pkg::Add, 26, 4, 4)};
        prog[37] = {imm_form(vliw_pkg::Li, 27, 0, 85), imm_form(vliw_pkg::Li, 27, 0, 102)};
        prog[38] = {jump_form(vliw_pkg::End, 0), 32'd0};
        prog[39] = {imm_form(vliw_pkg::Li, 28, 0, 16'h0BAD), 32'd0};
        repeat (8) @(posedge clk);
        rstn <= 1'b1;
        wait (halted);
        // Let the pipeline drain after End
        repeat (8) @(posedge clk);
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        #(prog_len * 8 * clk_period + 8 * clk_period);
        $display("Timeout: the program never reached End");
        $display("Errors: %0d", errors);
        $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
+incdir+hdl
hdl/vliw_pkg.sv
hdl/gpr_file.sv
hdl/bundle_decode.sv
hdl/slot_alu.sv
hdl/slot_result.sv
hdl/vliw_core.sv
dv/vliw_core_tb.sv

// File: Bender.yml
package:
  name: vliw_core

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/vliw_pkg.sv
      - hdl/gpr_file.sv
      - hdl/bundle_decode.sv
      - hdl/slot_alu.sv
      - hdl/slot_result.sv
      - hdl/vliw_core.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - dv/vliw_core_tb.sv
